// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = uart_loader_tb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log

SIM     = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -E '\.s?v$$' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '^ALL CHECKS PASSED$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== compile.f ====
hdl/uart_loader_pkg.sv
hdl/baud_tick_gen.sv
hdl/uart_rx.sv
hdl/word_assembler.sv
hdl/program_loader.sv
hdl/instr_mem.sv
hdl/uart_program_loader.sv
verification/uart_loader_tb.sv

// ==== hdl/baud_tick_gen.sv ====
`default_nettype none
`timescale 1ns/10ps

module baud_tick_gen
(
	input  logic clk,
	input  logic reset,
	output logic tick
);

	// last count before wrap
	localparam uart_loader_pkg::tick_cnt_t TICK_LAST =
		uart_loader_pkg::tick_cnt_t'(uart_loader_pkg::CLKS_PER_TICK - 1);

	uart_loader_pkg::tick_cnt_t cnt;

	// free-running divider, no sync to the line
	// the receiver aligns itself to the start edge in tick units
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt <= '0;
			tick <= 1'b0;
		end
		else
		begin
			// one clock wide pulse on wrap
			tick <= (cnt == TICK_LAST);
			if (cnt == TICK_LAST)
			begin
				cnt <= '0;
			end
			else
			begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/instr_mem.sv ====
`default_nettype none
`timescale 1ns/10ps

module instr_mem
(
	input  logic clk,
	input  logic we,
	input  uart_loader_pkg::imem_addr_t waddr,
	input  uart_loader_pkg::word_t wdata,
	input  uart_loader_pkg::imem_addr_t raddr,
	output uart_loader_pkg::word_t rdata
);

	// plain array, maps onto block ram
	uart_loader_pkg::word_t mem [uart_loader_pkg::IMEM_DEPTH];

	// write port, loader side
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[waddr] <= wdata;
		end
	end

	// read port, fetch side
	// one cycle latency, old data on a same-address write
	always_ff @(posedge clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// ==== hdl/program_loader.sv ====
`default_nettype none
`timescale 1ns/10ps

module program_loader
(
	input  logic clk,
	input  logic reset,
	input  logic word_valid,
	input  uart_loader_pkg::word_t word_data,
	output logic mem_we,
	output uart_loader_pkg::imem_addr_t mem_waddr,
	output uart_loader_pkg::word_t mem_wdata,
	output logic cpu_enable,
	output uart_loader_pkg::word_count_t loaded_words
);

	typedef enum logic
	{
		LD_LOADING,
		LD_RUNNING
	} load_state_t;

	// count value of the last free slot
	localparam uart_loader_pkg::word_count_t LAST_SLOT =
		uart_loader_pkg::word_count_t'(uart_loader_pkg::IMEM_DEPTH - 1);

	load_state_t state;
	logic is_marker;

	assign is_marker = (word_data == uart_loader_pkg::END_MARKER);

	// write straight through in the valid cycle, lands on the next edge
	assign mem_we = word_valid && !is_marker && (state == LD_LOADING);
	// count doubles as write address
	assign mem_waddr = loaded_words[uart_loader_pkg::IMEM_ADDR_W-1:0];
	assign mem_wdata = word_data;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= LD_LOADING;
			loaded_words <= '0;
		end
		else
		begin
			case (state)
				LD_LOADING:
				begin
					if (word_valid)
					begin
						if (is_marker)
						begin
							// marker is neither stored nor counted
							state <= LD_RUNNING;
						end
						else
						begin
							loaded_words <= loaded_words + 1'b1;
							// memory full, start the cpu without a marker
							if (loaded_words == LAST_SLOT)
							begin
								state <= LD_RUNNING;
							end
						end
					end
				end
				LD_RUNNING:
				begin
					// words ignored until reset
					state <= LD_RUNNING;
				end
				default:
				begin
					state <= LD_LOADING;
				end
			endcase
		end
	end

	// high from the cycle after the marker, falls only on reset
	assign cpu_enable = (state == LD_RUNNING);

endmodule

`default_nettype wire

// ==== hdl/uart_loader_pkg.sv ====
`default_nettype none

package uart_loader_pkg;

	// serial frame, 8N1
	localparam int DATA_BITS = 8;
	localparam int BIT_CNT_W = $clog2(DATA_BITS);

	// rx sampling, 16 samples per bit
	localparam int OVERSAMPLE = 16;
	localparam int OS_CNT_W = $clog2(OVERSAMPLE);

	// clocks per sample tick, so one bit is 32 clocks
	localparam int CLKS_PER_TICK = 2;
	localparam int TICK_CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;

	// msb-first packing of four bytes per instruction word
	localparam int BYTES_PER_WORD = 4;
	localparam int SLOT_W = $clog2(BYTES_PER_WORD);

	// instruction memory geometry
	localparam int IMEM_ADDR_W = 8;
	localparam int IMEM_DEPTH = 256;

	typedef logic [DATA_BITS-1:0] byte_t;
	typedef logic [DATA_BITS*BYTES_PER_WORD-1:0] word_t;
	typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;
	// one extra bit so a full memory still fits
	typedef logic [IMEM_ADDR_W:0] word_count_t;

	// internal counters
	typedef logic [TICK_CNT_W-1:0] tick_cnt_t;
	typedef logic [OS_CNT_W-1:0] os_cnt_t;
	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
	typedef logic [SLOT_W-1:0] slot_t;

	// reserved word, ends the load and starts the cpu
	localparam word_t END_MARKER = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// ==== hdl/uart_program_loader.sv ====
`default_nettype none
`timescale 1ns/10ps

module uart_program_loader
(
	input  logic clk,
	input  logic reset,
	input  logic rx,
	input  uart_loader_pkg::imem_addr_t fetch_addr,
	output uart_loader_pkg::word_t fetch_data,
	output logic cpu_enable,
	output uart_loader_pkg::word_count_t loaded_words,
	output logic rx_error
);

	logic tick;
	logic byte_valid;
	uart_loader_pkg::byte_t byte_data;
	logic frame_error;
	logic word_valid;
	uart_loader_pkg::word_t word_data;
	logic mem_we;
	uart_loader_pkg::imem_addr_t mem_waddr;
	uart_loader_pkg::word_t mem_wdata;

	// sample tick for the receiver
	baud_tick_gen i_baud_tick_gen
	(
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	// serial line to bytes
	uart_rx i_uart_rx
	(
		.clk         (clk),
		.reset       (reset),
		.tick        (tick),
		.rx          (rx),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.frame_error (frame_error)
	);

	// bytes to words, msb first
	word_assembler i_word_assembler
	(
		.clk        (clk),
		.reset      (reset),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.word_valid (word_valid),
		.word_data  (word_data)
	);

	// words to memory, marker starts the cpu
	program_loader i_program_loader
	(
		.clk          (clk),
		.reset        (reset),
		.word_valid   (word_valid),
		.word_data    (word_data),
		.mem_we       (mem_we),
		.mem_waddr    (mem_waddr),
		.mem_wdata    (mem_wdata),
		.cpu_enable   (cpu_enable),
		.loaded_words (loaded_words)
	);

	// fetch port stands in for the cpu
	instr_mem i_instr_mem
	(
		.clk   (clk),
		.we    (mem_we),
		.waddr (mem_waddr),
		.wdata (mem_wdata),
		.raddr (fetch_addr),
		.rdata (fetch_data)
	);

	// sticky framing error, cleared only by reset
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_error <= 1'b0;
		end
		else if (frame_error)
		begin
			rx_error <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
`default_nettype none
`timescale 1ns/10ps

module uart_rx
(
	input  logic clk,
	input  logic reset,
	input  logic tick,
	input  logic rx,
	output logic byte_valid,
	output uart_loader_pkg::byte_t byte_data,
	output logic frame_error
);

	typedef enum logic [1:0]
	{
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	// half a bit to confirm start, full bit between centres
	localparam uart_loader_pkg::os_cnt_t OS_HALF =
		uart_loader_pkg::os_cnt_t'(uart_loader_pkg::OVERSAMPLE / 2 - 1);
	localparam uart_loader_pkg::os_cnt_t OS_LAST =
		uart_loader_pkg::os_cnt_t'(uart_loader_pkg::OVERSAMPLE - 1);
	localparam uart_loader_pkg::bit_cnt_t BIT_LAST =
		uart_loader_pkg::bit_cnt_t'(uart_loader_pkg::DATA_BITS - 1);

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	uart_loader_pkg::os_cnt_t os_cnt;
	uart_loader_pkg::bit_cnt_t bit_cnt;
	uart_loader_pkg::byte_t shreg;

	// two-flop sync, third flop for falling-edge detect
	// all idle high out of reset so no false start
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= RX_IDLE;
			os_cnt <= '0;
			bit_cnt <= '0;
			byte_valid <= 1'b0;
			frame_error <= 1'b0;
		end
		else
		begin
			// strobes last one cycle
			byte_valid <= 1'b0;
			frame_error <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					os_cnt <= '0;
					// needs a real high-to-low edge, a line stuck low after a
					// bad stop bit does not restart the frame
					if (rx_prev && !rx_sync)
					begin
						state <= RX_START;
					end
				end
				RX_START:
				begin
					if (tick)
					begin
						if (os_cnt == OS_HALF)
						begin
							os_cnt <= '0;
							bit_cnt <= '0;
							// glitch shorter than half a bit, drop it
							state <= rx_sync ? RX_IDLE : RX_DATA;
						end
						else
						begin
							os_cnt <= os_cnt + 1'b1;
						end
					end
				end
				RX_DATA:
				begin
					if (tick)
					begin
						if (os_cnt == OS_LAST)
						begin
							os_cnt <= '0;
							if (bit_cnt == BIT_LAST)
							begin
								state <= RX_STOP;
							end
							else
							begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
						else
						begin
							os_cnt <= os_cnt + 1'b1;
						end
					end
				end
				RX_STOP:
				begin
					if (tick)
					begin
						if (os_cnt == OS_LAST)
						begin
							// stop bit centre decides byte or error
							byte_valid <= rx_sync;
							frame_error <= !rx_sync;
							os_cnt <= '0;
							state <= RX_IDLE;
						end
						else
						begin
							os_cnt <= os_cnt + 1'b1;
						end
					end
				end
				default:
				begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// lsb first, shift in from the top at each bit centre
	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && tick && os_cnt == OS_LAST)
		begin
			shreg <= {rx_sync, shreg[uart_loader_pkg::DATA_BITS-1:1]};
		end
	end

	// held through the stop state, so stable with byte_valid
	assign byte_data = shreg;

endmodule

`default_nettype wire

// ==== hdl/word_assembler.sv ====
`default_nettype none
`timescale 1ns/10ps

module word_assembler
(
	input  logic clk,
	input  logic reset,
	input  logic byte_valid,
	input  uart_loader_pkg::byte_t byte_data,
	output logic word_valid,
	output uart_loader_pkg::word_t word_data
);

	localparam uart_loader_pkg::slot_t SLOT_LAST =
		uart_loader_pkg::slot_t'(uart_loader_pkg::BYTES_PER_WORD - 1);

	// which byte of the word comes next, 0 is the msb lane
	uart_loader_pkg::slot_t slot;
	uart_loader_pkg::word_t word_reg;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			slot <= '0;
			word_valid <= 1'b0;
		end
		else
		begin
			// one-cycle pulse, independent of the next strobe
			word_valid <= byte_valid && (slot == SLOT_LAST);
			if (byte_valid)
			begin
				// wraps back to the msb lane after the fourth byte
				slot <= slot + 1'b1;
			end
		end
	end

	// lane fill, first byte of a group into 31:24
	always_ff @(posedge clk)
	begin
		if (byte_valid)
		begin
			word_reg[(SLOT_LAST - slot) * uart_loader_pkg::DATA_BITS +:
				uart_loader_pkg::DATA_BITS] <= byte_data;
		end
	end

	// complete word is stable until the next byte lands
	assign word_data = word_reg;

endmodule

`default_nettype wire

// ==== verification/uart_loader_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module uart_loader_tb;

	// one serial bit in clocks
	localparam int BIT_CLKS = uart_loader_pkg::OVERSAMPLE * uart_loader_pkg::CLKS_PER_TICK;
	// start, 8 data, stop, plus one idle bit after each frame
	localparam int FRAME_BITS = 11;
	// 36 for the load, 8 ignored after enable, 9 after the second reset
	localparam int TOTAL_FRAMES = 53;
	localparam int CYCLE_LIMIT = 2 * TOTAL_FRAMES * FRAME_BITS * BIT_CLKS + 1000;
	// bounded wait for a flag
	localparam int WAIT_LIMIT = 4 * BIT_CLKS;
	localparam int NUM_WORDS = 8;
	localparam int NUM_DROPPED = 2;

	logic clk = 1'b0;
	logic reset;
	logic rx;
	uart_loader_pkg::imem_addr_t fetch_addr;
	uart_loader_pkg::word_t fetch_data;
	logic cpu_enable;
	uart_loader_pkg::word_count_t loaded_words;
	logic rx_error;

	int errors;
	int monitor_errors = 0;
	int cycle_count = 0;
	integer seed;
	logic cpu_was_on = 1'b0;
	// own copy of the program
	uart_loader_pkg::word_t sent_words [NUM_WORDS];
	// words sent after enable, must land nowhere
	uart_loader_pkg::word_t dropped_words [NUM_DROPPED];

	uart_program_loader i_dut
	(
		.clk          (clk),
		.reset        (reset),
		.rx           (rx),
		.fetch_addr   (fetch_addr),
		.fetch_data   (fetch_data),
		.cpu_enable   (cpu_enable),
		.loaded_words (loaded_words),
		.rx_error     (rx_error)
	);

	// 4 ns period
	always #2 clk = ~clk;

	task automatic compare_flag(input string name, input logic exp, input logic act);
		assert (act === exp)
		else
		begin
			$display("MISMATCH at %0t: %s expected %0b got %0b", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic count_equals(input string name, input uart_loader_pkg::word_count_t exp,
		input uart_loader_pkg::word_count_t act);
		assert (act === exp)
		else
		begin
			$display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic word_matches(input string name, input uart_loader_pkg::word_t exp,
		input uart_loader_pkg::word_t act);
		assert (act === exp)
		else
		begin
			$display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	// one bit time, starting on a falling edge
	task automatic drive_bit(input logic value);
		@(negedge clk);
		rx = value;
		repeat (BIT_CLKS - 1) @(negedge clk);
	endtask

	// 8N1 frame, lsb first, then one idle bit so a low stop still leaves an edge
	task automatic send_frame(input uart_loader_pkg::byte_t data, input logic bad_stop);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
		begin
			drive_bit(data[i]);
		end
		drive_bit(!bad_stop);
		drive_bit(1'b1);
	endtask

	// msb byte goes out first
	task automatic send_word(input uart_loader_pkg::word_t w);
		send_frame(w[31:24], 1'b0);
		send_frame(w[23:16], 1'b0);
		send_frame(w[15:8], 1'b0);
		send_frame(w[7:0], 1'b0);
	endtask

	// random program word, never the marker
	function automatic uart_loader_pkg::word_t draw_word();
		uart_loader_pkg::word_t w;
		w = $random(seed);
		while (w == uart_loader_pkg::END_MARKER)
		begin
			w = $random(seed);
		end
		return w;
	endfunction

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		repeat (4) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic wait_cpu_enable();
		int n;
		n = 0;
		while (!cpu_enable && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		assert (cpu_enable)
		else
		begin
			$display("cpu_enable did not rise within %0d cycles, at %0t", WAIT_LIMIT, $time);
			errors++;
		end
	endtask

	task automatic wait_rx_error();
		int n;
		n = 0;
		while (!rx_error && n < WAIT_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		assert (rx_error)
		else
		begin
			$display("rx_error did not rise within %0d cycles, at %0t", WAIT_LIMIT, $time);
			errors++;
		end
	endtask

	// registered read, data one cycle after the address
	task automatic fetch_and_compare(input uart_loader_pkg::imem_addr_t addr,
		input uart_loader_pkg::word_t exp);
		@(negedge clk);
		fetch_addr = addr;
		@(negedge clk);
		word_matches($sformatf("fetch_data[%0d]", addr), exp, fetch_data);
	endtask

	// a dropped word must not show up at the next free address
	task automatic confirm_not_stored(input uart_loader_pkg::imem_addr_t addr,
		input uart_loader_pkg::word_t dropped);
		@(negedge clk);
		fetch_addr = addr;
		@(negedge clk);
		assert (fetch_data !== dropped)
		else
		begin
			$display("word %h sent after enable was stored at address %0d, at %0t",
				dropped, addr, $time);
			errors++;
		end
	endtask

	// quiet line, outputs must hold their reset values
	task automatic idle_check(input int cycles);
		int n;
		for (n = 0; n < cycles; n++)
		begin
			@(negedge clk);
			compare_flag("cpu_enable", 1'b0, cpu_enable);
			compare_flag("rx_error", 1'b0, rx_error);
			count_equals("loaded_words", '0, loaded_words);
		end
	endtask

	// cpu_enable only drops under reset
	always @(negedge clk)
	begin
		if (!reset && cpu_was_on)
		begin
			assert (cpu_enable)
			else
			begin
				$display("cpu_enable fell without a reset at %0t", $time);
				monitor_errors++;
			end
		end
		cpu_was_on <= !reset && cpu_enable;
	end

	// hang guard
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("timeout, run still going after %0d cycles", cycle_count);
			$display("check errors: %0d, monitor errors: %0d", errors, monitor_errors);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial
	begin
		int i;
		reset = 1'b1;
		rx = 1'b1;
		fetch_addr = '0;
		errors = 0;
		seed = 32'h8eb6_38e3;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// quiet after reset
		idle_check(2 * BIT_CLKS);

		// eight words, counted but not yet running
		for (i = 0; i < NUM_WORDS; i++)
		begin
			sent_words[i] = draw_word();
			send_word(sent_words[i]);
		end
		compare_flag("cpu_enable", 1'b0, cpu_enable);
		count_equals("loaded_words", uart_loader_pkg::word_count_t'(NUM_WORDS), loaded_words);

		// marker starts the cpu, not counted
		send_word(uart_loader_pkg::END_MARKER);
		wait_cpu_enable();
		count_equals("loaded_words", uart_loader_pkg::word_count_t'(NUM_WORDS), loaded_words);

		// contents and byte order
		for (i = 0; i < NUM_WORDS; i++)
		begin
			fetch_and_compare(uart_loader_pkg::imem_addr_t'(i), sent_words[i]);
		end

		// words after enable are dropped
		for (i = 0; i < NUM_DROPPED; i++)
		begin
			dropped_words[i] = draw_word();
			send_word(dropped_words[i]);
		end
		repeat (2 * BIT_CLKS) @(negedge clk);
		compare_flag("cpu_enable", 1'b1, cpu_enable);
		count_equals("loaded_words", uart_loader_pkg::word_count_t'(NUM_WORDS), loaded_words);
		for (i = 0; i < NUM_WORDS; i++)
		begin
			fetch_and_compare(uart_loader_pkg::imem_addr_t'(i), sent_words[i]);
		end
		for (i = 0; i < NUM_DROPPED; i++)
		begin
			confirm_not_stored(uart_loader_pkg::imem_addr_t'(NUM_WORDS + i), dropped_words[i]);
		end

		// second reset clears everything
		apply_reset();
		compare_flag("cpu_enable", 1'b0, cpu_enable);
		compare_flag("rx_error", 1'b0, rx_error);
		count_equals("loaded_words", '0, loaded_words);

		// bad stop bit, byte must not reach the assembler
		send_frame(8'hA5, 1'b1);
		wait_rx_error();
		sent_words[0] = draw_word();
		send_word(sent_words[0]);
		send_word(uart_loader_pkg::END_MARKER);
		wait_cpu_enable();
		count_equals("loaded_words", uart_loader_pkg::word_count_t'(1), loaded_words);
		compare_flag("rx_error", 1'b1, rx_error);
		fetch_and_compare('0, sent_words[0]);

		$display("check errors: %0d, monitor errors: %0d", errors, monitor_errors);
		if (errors == 0 && monitor_errors == 0)
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
